/* cmp/cmp_queue.sv */
`timescale 1ns/1ps

module cmp_queue import branch_pkg::*; (
	input logic clk,
	input logic cmp_push,
	input logic dispatch,
	input count_t cmp_count,
	input cmp_op_t op,
	input logic a_valid,
	input logic b_valid,
	input tag_t a_tag,
	input tag_t b_tag,
	input data_t a_data,
	input data_t b_data,
	input logic use_imm,
	input data_t imm,
	input logic gpr_cdb_valid,
	input logic fpr_cdb_valid,
	input tag_t gpr_cdb_tag,
	input tag_t fpr_cdb_tag,
	input data_t gpr_cdb_data,
	input data_t fpr_cdb_data,
	output logic head_ready,
	output cmp_op_t head_op,
	output data_t head_a,
	output data_t head_b
);
	cmp_op_t q_op [n_b_entry];
	logic q_a_valid [n_b_entry];
	logic q_b_valid [n_b_entry];
	tag_t q_a_tag [n_b_entry];
	tag_t q_b_tag [n_b_entry];
	data_t q_a_data [n_b_entry];
	data_t q_b_data [n_b_entry];

	// slot n_b_entry holds the incoming branch
	cmp_op_t s_op [n_b_entry+1];
	logic s_a_valid [n_b_entry+1];
	logic s_b_valid [n_b_entry+1];
	tag_t s_a_tag [n_b_entry+1];
	tag_t s_b_tag [n_b_entry+1];
	data_t s_a_data [n_b_entry+1];
	data_t s_b_data [n_b_entry+1];

	// after snooping the result buses
	logic w_a_valid [n_b_entry+1];
	logic w_b_valid [n_b_entry+1];
	data_t w_a_data [n_b_entry+1];
	data_t w_b_data [n_b_entry+1];

	logic new_int;
	logic imm_b;

	assign new_int = op == cmp_e || op == cmp_le;
	assign imm_b = new_int && use_imm;

	for (genvar i = 0; i < n_b_entry; i++) begin : g_src
		assign s_op[i] = q_op[i];
		assign s_a_valid[i] = q_a_valid[i];
		assign s_b_valid[i] = q_b_valid[i];
		assign s_a_tag[i] = q_a_tag[i];
		assign s_b_tag[i] = q_b_tag[i];
		assign s_a_data[i] = q_a_data[i];
		assign s_b_data[i] = q_b_data[i];
	end

	assign s_op[n_b_entry] = op;
	assign s_a_valid[n_b_entry] = a_valid;
	assign s_b_valid[n_b_entry] = b_valid || imm_b;
	assign s_a_tag[n_b_entry] = a_tag;
	assign s_b_tag[n_b_entry] = b_tag;
	assign s_a_data[n_b_entry] = a_data;
	assign s_b_data[n_b_entry] = imm_b ? imm : b_data;

	for (genvar i = 0; i <= n_b_entry; i++) begin : g_wake
		logic int_op;
		logic bus_valid;
		tag_t bus_tag;
		data_t bus_data;

		assign int_op = s_op[i] == cmp_e || s_op[i] == cmp_le;
		assign bus_valid = int_op ? gpr_cdb_valid : fpr_cdb_valid;
		assign bus_tag = int_op ? gpr_cdb_tag : fpr_cdb_tag;
		assign bus_data = int_op ? gpr_cdb_data : fpr_cdb_data;

		assign w_a_valid[i] = s_a_valid[i] || (bus_valid && bus_tag == s_a_tag[i]);
		assign w_b_valid[i] = s_b_valid[i] || (bus_valid && bus_tag == s_b_tag[i]);
		assign w_a_data[i] = s_a_valid[i] ? s_a_data[i] : bus_data;
		assign w_b_data[i] = s_b_valid[i] ? s_b_data[i] : bus_data;
	end

	always_ff @(posedge clk) begin
		int src;

		for (int i = 0; i < n_b_entry; i++) begin
			src = i + int'(dispatch); // shift toward head on dispatch
			if (src < int'(cmp_count) || cmp_push) begin
				if (src >= int'(cmp_count)) begin
					src = n_b_entry;
				end
				q_op[i] <= s_op[src];
				q_a_valid[i] <= w_a_valid[src];
				q_b_valid[i] <= w_b_valid[src];
				q_a_tag[i] <= s_a_tag[src];
				q_b_tag[i] <= s_b_tag[src];
				q_a_data[i] <= w_a_data[src];
				q_b_data[i] <= w_b_data[src];
			end
		end
	end

	// fz needs only operand a
	assign head_ready = cmp_count != 0 && q_a_valid[0] && (q_op[0] == cmp_fz || q_b_valid[0]);
	assign head_op = q_op[0];
	assign head_a = q_a_data[0];
	assign head_b = q_b_data[0];

endmodule

/* cmp/cmp_unit.sv */
`timescale 1ns/1ps

module cmp_unit import branch_pkg::*; (
	input cmp_op_t op,
	input data_t a,
	input data_t b,
	output logic cmp_result
);
	logic a_neg;
	logic b_neg;
	logic [f_sign-1:0] a_mag;
	logic [f_sign-1:0] b_mag;
	logic both_zero;
	logic fle;

	assign a_neg = a[f_sign];
	assign b_neg = b[f_sign];
	assign a_mag = a[f_sign-1:0];
	assign b_mag = b[f_sign-1:0];
	assign both_zero = a_mag == '0 && b_mag == '0; // +0 == -0

	always_comb begin
		if (both_zero) begin
			fle = 1'b1;
		end else if (a_neg != b_neg) begin
			fle = a_neg; // negative side is smaller
		end else if (a_neg) begin
			fle = a_mag >= b_mag;
		end else begin
			fle = a_mag <= b_mag;
		end
	end

	always_comb begin
		case (op)
			cmp_e: cmp_result = a == b;
			cmp_le: cmp_result = $signed(a) <= $signed(b);
			cmp_fle: cmp_result = fle;
			cmp_fz: cmp_result = a[f_exp_hi:f_exp_lo] == '0;
			default: cmp_result = 1'b0;
		endcase
	end

endmodule

/* common/branch_pkg.sv */
package branch_pkg;

	localparam int n_b_entry = 4;
	localparam int n_backup_entry = 4;
	localparam int stack_width = 3;
	localparam int n_stack = 1 << stack_width; // return stack slots

	// single precision fields
	localparam int f_sign = 31;
	localparam int f_exp_hi = 30;
	localparam int f_exp_lo = 23;

	typedef logic [31:0] data_t;
	typedef logic [4:0] tag_t;
	typedef logic [13:0] addr_t;
	typedef logic [stack_width-1:0] sp_t;

	// occupancy 0..n_b_entry, also used for backup counts
	typedef logic [$clog2(n_b_entry):0] count_t;
	typedef logic [$clog2(n_b_entry)-1:0] idx_t;

	typedef logic [1:0] pred_t; // msb is the taken guess

	typedef enum logic [1:0] {
		cmp_fz,
		cmp_fle,
		cmp_e,
		cmp_le
	} cmp_op_t;

endpackage

/* compile.f */
+incdir+verif
common/branch_pkg.sv
design/branch_ctrl.sv
cmp/cmp_queue.sv
cmp/cmp_unit.sv
design/branch_queue.sv
ras/ras.sv
design/branch_unit.sv
verif/branch_unit_tb.sv

/* design/branch_ctrl.sv */
`timescale 1ns/1ps

module branch_ctrl import branch_pkg::*; (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic issue_valid,
	input logic commit_valid,
	input logic head_ready,
	output logic issue_ready,
	output logic commit_ready,
	output logic cmp_push,
	output logic dispatch,
	output logic commit_en,
	output count_t b_count,
	output count_t cmp_count,
	output idx_t dispatch_idx
);
	count_t first_open;

	// head is resolved once fewer compares than branches remain
	assign commit_ready = cmp_count < b_count;
	assign commit_en = commit_valid && commit_ready;

	assign issue_ready = b_count < n_b_entry || commit_en;
	assign cmp_push = issue_valid && issue_ready;

	assign dispatch = head_ready;

	// oldest unresolved slot, after this cycle's commit shift
	assign first_open = b_count - cmp_count - count_t'(commit_en);
	assign dispatch_idx = first_open[$bits(idx_t)-1:0];

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			b_count <= '0;
		end else begin
			b_count <= b_count + count_t'(cmp_push) - count_t'(commit_en);
		end
	end

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			cmp_count <= '0;
		end else begin
			cmp_count <= cmp_count + count_t'(cmp_push) - count_t'(dispatch);
		end
	end

endmodule

/* design/branch_queue.sv */
`timescale 1ns/1ps

module branch_queue import branch_pkg::*; (
	input logic clk,
	input logic issue_en,
	input logic commit_en,
	input logic dispatch,
	input count_t b_count,
	input idx_t dispatch_idx,
	input logic cmp_result,
	input pred_t prediction_in,
	input addr_t fallback_in,
	input sp_t sp,
	output logic failure,
	output pred_t prediction_out,
	output addr_t fallback_addr,
	output sp_t head_sp
);
	logic fail_q [n_b_entry];
	pred_t pred_q [n_b_entry];
	addr_t fb_q [n_b_entry];
	sp_t sp_q [n_b_entry];

	logic fail_m [n_b_entry];
	pred_t pred_m [n_b_entry];
	addr_t fb_m [n_b_entry];
	sp_t sp_m [n_b_entry];

	// shift on commit, new branch lands in first free slot
	always_comb begin
		int src;

		for (int i = 0; i < n_b_entry; i++) begin
			src = i + int'(commit_en);
			if (src < int'(b_count)) begin
				fail_m[i] = fail_q[src];
				pred_m[i] = pred_q[src];
				fb_m[i] = fb_q[src];
				sp_m[i] = sp_q[src];
			end else if (issue_en) begin
				fail_m[i] = 1'b0;
				pred_m[i] = prediction_in;
				fb_m[i] = fallback_in;
				sp_m[i] = sp; // stack state at issue
			end else begin
				fail_m[i] = fail_q[i];
				pred_m[i] = pred_q[i];
				fb_m[i] = fb_q[i];
				sp_m[i] = sp_q[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < n_b_entry; i++) begin
			fail_q[i] <= fail_m[i]
				|| (dispatch && dispatch_idx == idx_t'(i) && cmp_result != pred_m[i][1]);
			pred_q[i] <= pred_m[i];
			fb_q[i] <= fb_m[i];
			sp_q[i] <= sp_m[i];
		end
	end

	assign failure = b_count != 0 && fail_q[0];
	assign prediction_out = pred_q[0];
	assign fallback_addr = fb_q[0];
	assign head_sp = sp_q[0];

endmodule

/* design/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit import branch_pkg::*; (
	input logic clk,
	input logic reset,
	input logic flush,
	input cmp_op_t op,
	input logic a_valid,
	input logic b_valid,
	input tag_t a_tag,
	input tag_t b_tag,
	input data_t a_data,
	input data_t b_data,
	input logic use_imm,
	input data_t imm,
	input pred_t prediction_in,
	input addr_t fallback_in,
	input logic gpr_cdb_valid,
	input tag_t gpr_cdb_tag,
	input data_t gpr_cdb_data,
	input logic fpr_cdb_valid,
	input tag_t fpr_cdb_tag,
	input data_t fpr_cdb_data,
	input logic issue_valid,
	output logic issue_ready,
	input logic commit_valid,
	output logic commit_ready,
	output logic failure,
	output pred_t prediction_out,
	output addr_t fallback_addr,
	input logic jal_valid,
	output logic jal_ready,
	input logic jr,
	input addr_t pc,
	output addr_t return_addr
);
	logic cmp_push;
	logic dispatch;
	logic commit_en;
	logic head_ready;
	logic cmp_result;
	count_t b_count;
	count_t cmp_count;
	idx_t dispatch_idx;
	cmp_op_t head_op;
	data_t head_a;
	data_t head_b;
	sp_t sp;
	sp_t head_sp;

	branch_ctrl u_ctrl (
		.clk, .reset, .flush,
		.issue_valid, .commit_valid, .head_ready,
		.issue_ready, .commit_ready,
		.cmp_push, .dispatch, .commit_en,
		.b_count, .cmp_count, .dispatch_idx
	);

	cmp_queue u_cmp_queue (
		.clk, .cmp_push, .dispatch, .cmp_count,
		.op, .a_valid, .b_valid, .a_tag, .b_tag, .a_data, .b_data,
		.use_imm, .imm,
		.gpr_cdb_valid, .fpr_cdb_valid, .gpr_cdb_tag, .fpr_cdb_tag,
		.gpr_cdb_data, .fpr_cdb_data,
		.head_ready, .head_op, .head_a, .head_b
	);

	cmp_unit u_cmp_unit (
		.op(head_op),
		.a(head_a),
		.b(head_b),
		.cmp_result
	);

	branch_queue u_branch_queue (
		.clk, .issue_en(cmp_push), .commit_en, .dispatch,
		.b_count, .dispatch_idx, .cmp_result,
		.prediction_in, .fallback_in, .sp,
		.failure, .prediction_out, .fallback_addr, .head_sp
	);

	ras u_ras (
		.clk, .reset, .flush,
		.jal_valid, .jr, .commit_en, .pc,
		.b_count, .head_sp,
		.jal_ready, .sp, .return_addr
	);

endmodule

/* ras/ras.sv */
`timescale 1ns/1ps

module ras import branch_pkg::*; (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic jal_valid,
	input logic jr,
	input logic commit_en,
	input addr_t pc,
	input count_t b_count,
	input sp_t head_sp,
	output logic jal_ready,
	output sp_t sp,
	output addr_t return_addr
);
	addr_t stack_q [n_stack];
	addr_t stack_next [n_stack];
	sp_t sp_q;
	sp_t sp_next;
	sp_t sp_inc;

	count_t bk_count;
	count_t bk_cnt [n_backup_entry]; // unresolved branches ahead
	sp_t bk_idx [n_backup_entry];
	addr_t bk_addr [n_backup_entry];

	count_t pending;
	count_t n_drop;
	count_t kept;
	logic jal_fire;
	logic bk_push;

	assign sp = sp_q;
	assign sp_inc = sp_q + 1'b1;
	assign pending = b_count - count_t'(commit_en); // left after this commit

	assign jal_ready = bk_count < n_backup_entry || (commit_en && bk_cnt[0] == count_t'(1));
	assign jal_fire = jal_valid && jal_ready && !flush;
	assign bk_push = jal_fire && pending != 0;

	// entries ahead of only the committing branch go away
	always_comb begin
		n_drop = '0;
		for (int i = 0; i < n_backup_entry; i++) begin
			if (commit_en && i < int'(bk_count) && bk_cnt[i] == count_t'(1)) begin
				n_drop = n_drop + 1'b1;
			end
		end
	end
	assign kept = bk_count - n_drop;

	always_ff @(posedge clk) begin
		if (reset || flush) begin
			bk_count <= '0;
		end else begin
			bk_count <= kept + count_t'(bk_push);
		end
	end

	always_ff @(posedge clk) begin
		int src;

		for (int i = 0; i < n_backup_entry; i++) begin
			src = i + int'(n_drop);
			if (src < int'(bk_count)) begin
				bk_cnt[i] <= bk_cnt[src] - count_t'(commit_en);
				bk_idx[i] <= bk_idx[src];
				bk_addr[i] <= bk_addr[src];
			end else if (bk_push && i == int'(kept)) begin
				bk_cnt[i] <= pending;
				bk_idx[i] <= sp_inc;
				bk_addr[i] <= stack_q[sp_inc]; // slot about to be overwritten
			end
		end
	end

	always_comb begin
		if (reset) begin
			sp_next = sp_t'(n_stack - 1);
		end else if (flush) begin
			sp_next = head_sp;
		end else if (jal_fire) begin
			sp_next = sp_inc;
		end else if (jr) begin
			sp_next = sp_q - 1'b1;
		end else begin
			sp_next = sp_q;
		end
	end

	always_comb begin
		stack_next = stack_q;
		if (flush) begin
			// oldest backup of a slot wins
			for (int i = n_backup_entry - 1; i >= 0; i--) begin
				if (i < int'(bk_count)) begin
					stack_next[bk_idx[i]] = bk_addr[i];
				end
			end
		end else if (jal_fire) begin
			stack_next[sp_inc] = pc;
		end
	end

	always_ff @(posedge clk) begin
		sp_q <= sp_next;
	end

	always_ff @(posedge clk) begin
		stack_q <= stack_next;
		return_addr <= stack_next[sp_next];
	end

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the branch unit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f compile.f --top-module branch_unit_tb -o sim \
	&& ./obj_dir/sim | grep "Verification passed" \
	|| { echo "simulation did not pass"; exit 1; }

/* verif/branch_model.svh */
`ifndef BRANCH_MODEL_SVH
`define BRANCH_MODEL_SVH

// expected head outcomes in issue order
logic exp_fail [$];
pred_t exp_pred [$];
addr_t exp_fb [$];

// model return stack
addr_t m_stack [n_stack];
int m_sp = n_stack - 1;
addr_t snap_stack [n_stack];
int snap_sp;

function automatic logic model_fle(data_t a, data_t b);
	int ka;
	int kb;

	// signed number line where both zeros meet at 0
	ka = a[31] ? -int'(a[30:0]) : int'(a[30:0]);
	kb = b[31] ? -int'(b[30:0]) : int'(b[30:0]);
	return ka <= kb;
endfunction

function automatic logic model_cmp(cmp_op_t o, data_t a, data_t b);
	case (o)
		cmp_e: return a == b;
		cmp_le: return $signed(a) <= $signed(b);
		cmp_fle: return model_fle(a, b);
		default: return a[30:23] == 8'd0;
	endcase
endfunction

task automatic model_issue(logic result, pred_t p, addr_t fb);
	if (exp_fail.size() == 0) begin
		snap_stack = m_stack; // stack as the oldest branch saw it
		snap_sp = m_sp;
	end
	exp_fail.push_back(result ^ p[1]);
	exp_pred.push_back(p);
	exp_fb.push_back(fb);
endtask

task automatic model_push(addr_t a);
	m_sp = (m_sp + 1) % n_stack;
	m_stack[m_sp] = a;
endtask

task automatic model_pop();
	m_sp = (m_sp + n_stack - 1) % n_stack;
endtask

// a flush returns the stack to its state at the oldest branch
task automatic model_flush();
	m_stack = snap_stack;
	m_sp = snap_sp;
	exp_fail.delete();
	exp_pred.delete();
	exp_fb.delete();
endtask

`endif

/* verif/branch_unit_tb.sv */
`timescale 1ns/1ps

module branch_unit_tb import branch_pkg::*; ();
	// rough cycle budget per test, summed
	localparam int test_len_sum = 100 + 150 + 100 + 60 + 80 + 60;
	localparam int cycle_limit = 2 * test_len_sum;

	logic clk, reset, flush;
	cmp_op_t op;
	logic a_valid, b_valid, use_imm;
	tag_t a_tag, b_tag;
	data_t a_data, b_data, imm;
	pred_t prediction_in, prediction_out;
	addr_t fallback_in, fallback_addr, pc, return_addr;
	logic gpr_cdb_valid, fpr_cdb_valid;
	tag_t gpr_cdb_tag, fpr_cdb_tag;
	data_t gpr_cdb_data, fpr_cdb_data;
	logic issue_valid, issue_ready, commit_valid, commit_ready, failure;
	logic jal_valid, jal_ready, jr;

	integer seed = 98115;
	int cycles = 0;
	int errors = 0;
	int test_errors = 0;
	int n_tests = 0;
	string test_name;

	`include "branch_model.svh"

	branch_unit u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout: run exceeded %0d cycles", cycle_limit);
			$display("Verification failed");
			$finish;
		end
	end

	task automatic check(string what, logic [31:0] expected, logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAILED %s: %s expected %h actual %h", test_name, what, expected, actual);
			errors++;
			test_errors++;
		end
	endtask

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic end_test();
		$display("test %s: done, %0d errors", test_name, test_errors);
		n_tests++;
		test_errors = 0;
	endtask

	task automatic issue_branch(cmp_op_t o, logic av, tag_t at, data_t ad,
			logic bv, tag_t bt, data_t bd, logic ui, data_t im);
		pred_t p;
		addr_t fb;
		logic ok;
		data_t bval;

		p = pred_t'($random(seed));
		fb = addr_t'($random(seed));
		bval = (ui && (o == cmp_e || o == cmp_le)) ? im : bd;
		model_issue(model_cmp(o, ad, bval), p, fb);
		op = o;
		a_valid = av;
		a_tag = at;
		a_data = ad;
		b_valid = bv;
		b_tag = bt;
		b_data = bd;
		use_imm = ui;
		imm = im;
		prediction_in = p;
		fallback_in = fb;
		issue_valid = 1'b1;
		do begin
			#1 ok = issue_ready;
			step();
		end while (!ok);
		issue_valid = 1'b0;
	endtask

	task automatic commit_one();
		logic ok;

		commit_valid = 1'b1;
		do begin
			#1 ok = commit_ready;
			if (ok) begin
				if (exp_fail.size() == 0) begin
					$display("%s: commit offered with no branch outstanding", test_name);
					errors++;
					test_errors++;
				end else begin
					check("failure", exp_fail.pop_front(), failure);
					check("prediction_out", exp_pred.pop_front(), prediction_out);
					check("fallback_addr", exp_fb.pop_front(), fallback_addr);
				end
			end
			step();
		end while (!ok);
		commit_valid = 1'b0;
	endtask

	task automatic broadcast(logic on_fpr, tag_t t, data_t d);
		tag_t other;

		other = tag_t'(16 + {$random(seed)} % 15); // never a pending tag
		gpr_cdb_valid = 1'b1;
		fpr_cdb_valid = 1'b1;
		gpr_cdb_tag = on_fpr ? other : t;
		fpr_cdb_tag = on_fpr ? t : other;
		gpr_cdb_data = on_fpr ? data_t'($random(seed)) : d;
		fpr_cdb_data = on_fpr ? d : data_t'($random(seed));
		step();
		gpr_cdb_valid = 1'b0;
		fpr_cdb_valid = 1'b0;
	endtask

	function automatic data_t rand_float();
		int k;

		k = {$random(seed)} % 6;
		if (k == 0) return 32'h0000_0000;
		if (k == 1) return 32'h8000_0000;
		return {1'($random(seed)), 8'({$random(seed)} % 255), 23'($random(seed))};
	endfunction

	task automatic do_jal(addr_t a);
		logic ok;

		pc = a;
		jal_valid = 1'b1;
		do begin
			#1 ok = jal_ready;
			step();
		end while (!ok);
		jal_valid = 1'b0;
		model_push(a);
		check("return_addr after jal", m_stack[m_sp], return_addr);
	endtask

	task automatic do_jr();
		jr = 1'b1;
		step();
		jr = 1'b0;
		model_pop();
		check("return_addr after jr", m_stack[m_sp], return_addr);
	endtask

	task automatic random_ras_event();
		if ($random(seed) & 1) do_jal(addr_t'($random(seed)));
		else do_jr();
	endtask

	initial begin
		cmp_op_t o;
		data_t a, b, junk;
		logic pa, pb, f, ui;
		logic pend_f [$];
		tag_t pend_tag [$];
		data_t pend_data [$];
		data_t bp_a [4];
		tag_t t;
		int j;
		int head_left;

		{flush, issue_valid, commit_valid, jal_valid, jr, use_imm} = '0;
		{a_valid, b_valid, gpr_cdb_valid, fpr_cdb_valid} = '0;
		op = cmp_e;
		{a_tag, b_tag, gpr_cdb_tag, fpr_cdb_tag} = '0;
		{a_data, b_data, imm, gpr_cdb_data, fpr_cdb_data} = '0;
		prediction_in = '0;
		fallback_in = '0;
		pc = '0;
		reset = 1'b1;
		repeat (5) @(posedge clk);
		#1 reset = 1'b0;
		step();

		test_name = "reset";
		check("issue_ready after reset", 1'b1, issue_ready);
		check("jal_ready after reset", 1'b1, jal_ready);
		check("commit_ready after reset", 1'b0, commit_ready);
		check("failure after reset", 1'b0, failure);
		end_test();

		test_name = "int_compare";
		for (int r = 1; r <= 4; r++) begin
			for (int i = 0; i < r; i++) begin
				o = ($random(seed) & 1) ? cmp_e : cmp_le;
				a = $random(seed);
				b = ($random(seed) & 1) ? a : $random(seed);
				ui = $random(seed) & 1;
				junk = $random(seed);
				issue_branch(o, 1'b1, 5'd31, a, 1'b1, 5'd31, ui ? junk : b,
					ui, ui ? b : junk);
			end
			for (int i = 0; i < r; i++) commit_one();
		end
		end_test();

		test_name = "wakeup";
		for (int r = 0; r < 4; r++) begin
			head_left = 0;
			for (int i = 0; i < 3; i++) begin
				f = $random(seed) & 1;
				o = f ? (($random(seed) & 1) ? cmp_fle : cmp_fz) :
					(($random(seed) & 1) ? cmp_e : cmp_le);
				a = f ? rand_float() : $random(seed);
				b = ($random(seed) & 1) ? a : (f ? rand_float() : $random(seed));
				pa = (i == 0) || ($random(seed) & 1); // head always waits
				pb = o != cmp_fz && ($random(seed) & 1);
				if (pa) begin
					pend_f.push_back(f);
					pend_tag.push_back(tag_t'(2 * i));
					pend_data.push_back(a);
					head_left += (i == 0);
				end
				if (pb) begin
					pend_f.push_back(f);
					pend_tag.push_back(tag_t'(2 * i + 1));
					pend_data.push_back(b);
					head_left += (i == 0);
				end
				issue_branch(o, !pa, tag_t'(2 * i), a, !pb, tag_t'(2 * i + 1), b, 1'b0, '0);
			end
			for (int i = pend_tag.size() - 1; i > 0; i--) begin
				j = {$random(seed)} % (i + 1);
				f = pend_f[i];
				pend_f[i] = pend_f[j];
				pend_f[j] = f;
				a = pend_data[i];
				pend_data[i] = pend_data[j];
				pend_data[j] = a;
				t = pend_tag[i];
				pend_tag[i] = pend_tag[j];
				pend_tag[j] = t;
			end
			while (pend_tag.size() > 0) begin
				if (head_left > 0) begin
					check("commit_ready before head operands", 1'b0, commit_ready);
				end
				t = pend_tag.pop_front();
				if (t < 2) begin
					head_left--;
				end
				broadcast(pend_f.pop_front(), t, pend_data.pop_front());
			end
			repeat (3) commit_one();
		end
		end_test();

		test_name = "float_compare";
		for (int r = 0; r < 8; r++) begin
			for (int i = 0; i < 2; i++) begin
				o = ($random(seed) & 1) ? cmp_fle : cmp_fz;
				a = rand_float();
				b = ($random(seed) & 1) ? a : rand_float();
				issue_branch(o, 1'b1, 5'd31, a, 1'b1, 5'd31, b, 1'b0, '0);
			end
			repeat (2) commit_one();
		end
		end_test();

		test_name = "back_pressure";
		for (int i = 0; i < 4; i++) begin
			bp_a[i] = $random(seed);
			issue_branch(cmp_le, 1'b0, tag_t'(i), bp_a[i], 1'b1, 5'd31,
				$random(seed), 1'b0, '0);
		end
		check("issue_ready when full", 1'b0, issue_ready);
		a = $random(seed);
		fork
			issue_branch(cmp_e, 1'b1, 5'd31, a, 1'b1, 5'd31, a, 1'b0, '0); // held while full
			begin
				for (int i = 3; i >= 0; i--) begin
					check("commit_ready while head waits", 1'b0, commit_ready);
					broadcast(1'b0, tag_t'(i), bp_a[i]);
				end
				commit_one();
			end
		join
		repeat (4) commit_one();
		check("commit_ready when drained", 1'b0, commit_ready);
		check("issue_ready when drained", 1'b1, issue_ready);
		end_test();

		test_name = "return_stack";
		for (int i = 0; i < n_stack; i++) do_jal(addr_t'($random(seed)));
		for (int i = 0; i < 40; i++) random_ras_event();
		end_test();

		test_name = "flush_restore";
		issue_branch(cmp_e, 1'b0, 5'd7, $random(seed), 1'b1, 5'd31, $random(seed), 1'b0, '0);
		for (int i = 0; i < n_backup_entry; i++) begin
			do_jal(addr_t'($random(seed)));
			if ($random(seed) & 1) begin
				do_jr();
			end
		end
		check("jal_ready with backups full", 1'b0, jal_ready);
		flush = 1'b1;
		step();
		flush = 1'b0;
		model_flush();
		check("return_addr after flush", m_stack[m_sp], return_addr);
		check("jal_ready after flush", 1'b1, jal_ready);
		for (int i = 0; i < n_stack - 1; i++) do_jr();
		// queues must be empty, so the next branch is the head
		a = $random(seed);
		issue_branch(cmp_e, 1'b1, 5'd31, a, 1'b1, 5'd31, a, 1'b0, '0);
		commit_one();
		check("commit_ready after flush drain", 1'b0, commit_ready);
		end_test();

		$display("%0d tests, %0d errors", n_tests, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule
